/* logic/axis_projector.sv */
`timescale 1ns/1ps
`include "collision_defines.svh"

module axis_projector import rect_geom_pkg::*, sat_pkg::*; (
    input  rect_corners_t subject,
    input  rect_corners_t frame,
    output extent_t       extent
);

    coord_t dx [4];
    coord_t dy [4];
    prod_t  dot_u [4];
    prod_t  dot_v [4];
    proj_t  proj_u [4];
    proj_t  proj_v [4];

    logic   corners_covered;

    function automatic proj_t min2(proj_t a, proj_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic proj_t max2(proj_t a, proj_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // Corner position relative to the frame rectangle's centre
            dx[i] = subject.pt[i].x - frame.cx;
            dy[i] = subject.pt[i].y - frame.cy;

            dot_u[i] = prod_t'(dx[i]) * prod_t'(frame.u_x)
                     + prod_t'(dy[i]) * prod_t'(frame.u_y);
            dot_v[i] = prod_t'(dx[i]) * prod_t'(frame.v_x)
                     + prod_t'(dy[i]) * prod_t'(frame.v_y);

            proj_u[i] = proj_t'(dot_u[i] >>> `PROJ_SHIFT);
            proj_v[i] = proj_t'(dot_v[i] >>> `PROJ_SHIFT);
        end
    end

    // Pairwise tree over corners 0/1 and 2/3, then across the pairs
    always_comb begin
        extent.min_u = min2(min2(proj_u[0], proj_u[1]), min2(proj_u[2], proj_u[3]));
        extent.max_u = max2(max2(proj_u[0], proj_u[1]), max2(proj_u[2], proj_u[3]));
        extent.min_v = min2(min2(proj_v[0], proj_v[1]), min2(proj_v[2], proj_v[3]));
        extent.max_v = max2(max2(proj_v[0], proj_v[1]), max2(proj_v[2], proj_v[3]));
    end

    // Every corner has to fall inside the reduced range on both axes
    always_comb begin
        corners_covered = 1'b1;
        for (int i = 0; i < 4; i++) begin
            corners_covered &= (extent.min_u <= proj_u[i]) && (proj_u[i] <= extent.max_u) &&
                               (extent.min_v <= proj_v[i]) && (proj_v[i] <= extent.max_v);
        end
    end

    // Reduction must cover all four corners on both axes
    always_comb begin
        if (!$isunknown({subject, frame})) begin
            extent_covers_corners: assert final (corners_covered)
                else $error("axis_projector: a corner lies outside min/max");
        end
    end

endmodule

/* logic/collision_defines.svh */
`ifndef COLLISION_DEFINES_SVH
`define COLLISION_DEFINES_SVH

// Input formats
// Position is Q7.25, so 1.0 equals 2^25
`define POS_W         32
// Basis components are Q2.14, so 1.0 equals 2^14
`define BASIS_W       16
`define SIZE_W        8

// Half of a width or height
`define HALF_W        7

// Corner coordinates after the position has been scaled down
`define CORNER_W      23

// Full dot product of a 23-bit offset with a 16-bit basis component
`define PROD_W        39

// Projection result, same scale as a position
`define PROJ_W        32

// Shift that brings a position into corner units
`define POS_SHIFT     11

// Shift that brings a dot product into projection units
`define PROJ_SHIFT    3

// Shift that brings a half extent into projection units
`define EXTENT_SHIFT  25

`endif

/* logic/collision_detector.sv */
`timescale 1ns/1ps

module collision_detector import rect_geom_pkg::*, sat_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    output logic  in_ready,
    input  rect_t rect_a,
    input  rect_t rect_b,
    output logic  out_valid,
    input  logic  out_ready,
    output logic  is_collision
);

    stage1_t s1_in;
    stage1_t s1_out;
    logic    s1_valid;
    logic    s1_ready;

    stage2_t s2_in;
    stage2_t s2_out;
    logic    s2_valid;
    logic    s2_ready;

    logic    collide;

    // Stage 1 builds corners for both rectangles
    corner_gen u_corner_a (
        .rect    (rect_a),
        .corners (s1_in.a)
    );

    corner_gen u_corner_b (
        .rect    (rect_b),
        .corners (s1_in.b)
    );

    pipe_stage #(.payload_t(stage1_t)) u_stage1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (s1_in),
        .out_valid (s1_valid),
        .out_ready (s1_ready),
        .out_data  (s1_out)
    );

    // Stage 2 projects each rectangle onto the other's axes
    axis_projector u_proj_a_on_b (
        .subject (s1_out.a),
        .frame   (s1_out.b),
        .extent  (s2_in.a_on_b)
    );

    axis_projector u_proj_b_on_a (
        .subject (s1_out.b),
        .frame   (s1_out.a),
        .extent  (s2_in.b_on_a)
    );

    assign s2_in.half_w_a = s1_out.a.half_w;
    assign s2_in.half_h_a = s1_out.a.half_h;
    assign s2_in.half_w_b = s1_out.b.half_w;
    assign s2_in.half_h_b = s1_out.b.half_h;

    pipe_stage #(.payload_t(stage2_t)) u_stage2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s1_valid),
        .in_ready  (s1_ready),
        .in_data   (s2_in),
        .out_valid (s2_valid),
        .out_ready (s2_ready),
        .out_data  (s2_out)
    );

    // Stage 3 applies the eight separating tests
    separation_test u_sep (
        .stage        (s2_out),
        .is_collision (collide)
    );

    pipe_stage #(.payload_t(logic)) u_stage3 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s2_valid),
        .in_ready  (s2_ready),
        .in_data   (collide),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (is_collision)
    );

endmodule

/* logic/corner_gen.sv */
`timescale 1ns/1ps
`include "collision_defines.svh"

module corner_gen import rect_geom_pkg::*; (
    input  rect_t         rect,
    output rect_corners_t corners
);

    half_t  half_w;
    half_t  half_h;
    coord_t cx;
    coord_t cy;

    // Half extent scaled along each basis vector
    coord_t hu_x;
    coord_t hu_y;
    coord_t hv_x;
    coord_t hv_y;

    assign half_w = half_t'(rect.width >> 1);
    assign half_h = half_t'(rect.height >> 1);

    // Centre in corner units
    assign cx = coord_t'(rect.pos_x >>> `POS_SHIFT);
    assign cy = coord_t'(rect.pos_y >>> `POS_SHIFT);

    assign hu_x = coord_t'(half_w) * coord_t'(rect.u_x);
    assign hu_y = coord_t'(half_w) * coord_t'(rect.u_y);
    assign hv_x = coord_t'(half_h) * coord_t'(rect.v_x);
    assign hv_y = coord_t'(half_h) * coord_t'(rect.v_y);

    always_comb begin
        // Index bit 1 picks the sign along u, bit 0 the sign along v
        for (int i = 0; i < 4; i++) begin
            corners.pt[i].x = cx + (i[1] ? hu_x : -hu_x) + (i[0] ? hv_x : -hv_x);
            corners.pt[i].y = cy + (i[1] ? hu_y : -hu_y) + (i[0] ? hv_y : -hv_y);
        end
        corners.cx     = cx;
        corners.cy     = cy;
        corners.u_x    = rect.u_x;
        corners.u_y    = rect.u_y;
        corners.v_x    = rect.v_x;
        corners.v_y    = rect.v_y;
        corners.half_w = half_w;
        corners.half_h = half_h;
    end

endmodule

/* logic/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic full;

    // Can take a new item if empty or if the held item leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // An offered item must be held unchanged until this stage takes it
    offer_holds_data: assert property (
        @(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_data)
    ) else $error("pipe_stage: input changed while stalled");

endmodule

/* logic/rect_geom_pkg.sv */
`include "collision_defines.svh"

package rect_geom_pkg;

    typedef logic signed [`SIZE_W-1:0]   size_t;
    typedef logic signed [`HALF_W-1:0]   half_t;
    typedef logic signed [`POS_W-1:0]    pos_t;
    typedef logic signed [`BASIS_W-1:0]  basis_t;
    typedef logic signed [`CORNER_W-1:0] coord_t;

    // One rectangle as it arrives on the input stream
    typedef struct packed {
        size_t  width;
        size_t  height;
        pos_t   pos_x;
        pos_t   pos_y;
        basis_t u_x;
        basis_t u_y;
        basis_t v_x;
        basis_t v_y;
    } rect_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } corner_t;

    // Corners in order (-u,-v), (-u,+v), (+u,-v), (+u,+v), plus what later stages reuse
    typedef struct packed {
        corner_t [3:0] pt;
        coord_t        cx;
        coord_t        cy;
        basis_t        u_x;
        basis_t        u_y;
        basis_t        v_x;
        basis_t        v_y;
        half_t         half_w;
        half_t         half_h;
    } rect_corners_t;

endpackage

/* logic/sat_pkg.sv */
`include "collision_defines.svh"

package sat_pkg;

    import rect_geom_pkg::*;

    typedef logic signed [`PROD_W-1:0] prod_t;
    typedef logic signed [`PROJ_W-1:0] proj_t;

    // Projected extent of one rectangle on the axes of the other
    typedef struct packed {
        proj_t min_u;
        proj_t max_u;
        proj_t min_v;
        proj_t max_v;
    } extent_t;

    // Payload after corner generation
    typedef struct packed {
        rect_corners_t a;
        rect_corners_t b;
    } stage1_t;

    // Payload after projection
    typedef struct packed {
        extent_t a_on_b;
        extent_t b_on_a;
        half_t   half_w_a;
        half_t   half_h_a;
        half_t   half_w_b;
        half_t   half_h_b;
    } stage2_t;

endpackage

/* logic/separation_test.sv */
`timescale 1ns/1ps
`include "collision_defines.svh"

module separation_test import sat_pkg::*; (
    input  stage2_t stage,
    output logic    is_collision
);

    // Half extents in projection units
    proj_t lim_w_a;
    proj_t lim_h_a;
    proj_t lim_w_b;
    proj_t lim_h_b;

    logic [7:0] sep;

    assign lim_w_a = proj_t'(stage.half_w_a) <<< `EXTENT_SHIFT;
    assign lim_h_a = proj_t'(stage.half_h_a) <<< `EXTENT_SHIFT;
    assign lim_w_b = proj_t'(stage.half_w_b) <<< `EXTENT_SHIFT;
    assign lim_h_b = proj_t'(stage.half_h_b) <<< `EXTENT_SHIFT;

    always_comb begin
        // A projected on B's axes, against B's halves
        sep[0] = stage.a_on_b.min_u >= lim_w_b;
        sep[1] = stage.a_on_b.max_u <= -lim_w_b;
        sep[2] = stage.a_on_b.min_v >= lim_h_b;
        sep[3] = stage.a_on_b.max_v <= -lim_h_b;

        // B projected on A's axes, against A's halves
        sep[4] = stage.b_on_a.min_u >= lim_w_a;
        sep[5] = stage.b_on_a.max_u <= -lim_w_a;
        sep[6] = stage.b_on_a.min_v >= lim_h_a;
        sep[7] = stage.b_on_a.max_v <= -lim_h_a;
    end

    // Touching edges count as separated
    assign is_collision = ~|sep;

endmodule

/* tb.f */
+incdir+logic
logic/rect_geom_pkg.sv
logic/sat_pkg.sv
logic/pipe_stage.sv
logic/corner_gen.sv
logic/axis_projector.sv
logic/separation_test.sv
logic/collision_detector.sv
verification/collision_tb.sv

/* verification/collision_tb.sv */
`timescale 1ns/1ps

module collision_tb import rect_geom_pkg::*; ();

    localparam int NUM_CASES  = 9;
    localparam int MAX_CYCLES = NUM_CASES * 8 + 100;
    // Pipeline stages that can each hold one item
    localparam int DEPTH = 3;
    // cos 45 degrees with 1.0 at 2^14
    localparam int DIAG = 11585;

    typedef struct packed {
        rect_t a;
        rect_t b;
        logic  hit;
    } case_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    rect_t       rect_a;
    rect_t       rect_b;
    logic        out_valid;
    logic        out_ready;
    logic        is_collision;

    case_t       tbl [NUM_CASES];
    int          pending [$];
    integer      seed;
    int          cycles;
    int          errors;
    int          passes;
    int          edges;

    collision_detector dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Run timed out after %0d cycles with results still missing", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // Sizes and positions in whole units, turned rotates the basis by 45 degrees
    function automatic rect_t make_rect(int w, int h, int px, int py, bit turned);
        rect_t r;
        r.width  = size_t'(w);
        r.height = size_t'(h);
        r.pos_x  = pos_t'(px * (1 << 25));
        r.pos_y  = pos_t'(py * (1 << 25));
        r.u_x    = basis_t'(turned ? DIAG : 1 << 14);
        r.u_y    = basis_t'(turned ? DIAG : 0);
        r.v_x    = basis_t'(turned ? -DIAG : 0);
        r.v_y    = basis_t'(turned ? DIAG : 1 << 14);
        return r;
    endfunction

    // Streams the whole table while the consumer stalls at random
    task automatic run_stream();
        logic [31:0] rnd;
        logic        want_ready;
        int          sent;
        int          got;
        int          idx;
        sent = 0;
        got = 0;
        while (got < NUM_CASES) begin
            @(negedge clk);
            rnd = $random(seed);
            out_ready = rnd[0];
            in_valid = (sent < NUM_CASES);
            if (sent < NUM_CASES) begin
                rect_a = tbl[sent].a;
                rect_b = tbl[sent].b;
            end
            // Handshakes settle well before the next rising edge
            #1;
            // Input is refused only while every stage is full and nothing leaves
            want_ready = (sent - got < DEPTH) || out_ready;
            if (in_ready !== want_ready) begin
                $display("Mismatch with %0d in flight: in_ready expected %h actual %h",
                         sent - got, want_ready, in_ready);
                errors++;
            end
            if (out_valid && out_ready) begin
                got++;
                if (pending.size() == 0) begin
                    $display("A result arrived with no input outstanding");
                    errors++;
                end else begin
                    idx = pending.pop_front();
                    if (is_collision !== tbl[idx].hit) begin
                        $display("Mismatch test %0d: is_collision expected %h actual %h",
                                 idx, tbl[idx].hit, is_collision);
                        errors++;
                    end else begin
                        $display("Test %0d passed, is_collision %h", idx, is_collision);
                        passes++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                pending.push_back(sent);
                sent++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        rect_a = '0;
        rect_b = '0;
        out_ready = 1'b0;
        seed = 32'he467c482;
        cycles = 0;
        errors = 0;
        passes = 0;

        tbl[0] = '{make_rect(16, 16, 0, 0, 0), make_rect(16, 16, 4, 0, 0), 1'b1};
        tbl[1] = '{make_rect(16, 16, 0, 0, 0), make_rect(16, 16, 20, 0, 0), 1'b0};
        // Edges meet exactly
        tbl[2] = '{make_rect(16, 16, 0, 0, 0), make_rect(16, 16, 16, 0, 0), 1'b0};
        tbl[3] = '{make_rect(16, 16, 0, 0, 0), make_rect(16, 16, 0, -20, 0), 1'b0};
        // Clear only along the diamond's own axis
        tbl[4] = '{make_rect(16, 16, 0, 0, 0), make_rect(16, 16, 16, 16, 1), 1'b0};
        tbl[5] = '{make_rect(16, 16, 0, 0, 1), make_rect(16, 16, 16, 16, 0), 1'b0};
        tbl[6] = '{make_rect(16, 16, 0, 0, 0), make_rect(16, 16, 8, 8, 1), 1'b1};
        tbl[7] = '{make_rect(16, 16, 0, 0, 0), make_rect(4, 4, 0, 0, 0), 1'b1};
        tbl[8] = '{make_rect(32, 8, 0, 0, 0), make_rect(16, 16, 20, 0, 0), 1'b1};

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset state and latency through the three stages
        if (out_valid !== 1'b0) begin
            $display("out_valid is not low after reset");
            errors++;
        end else begin
            $display("Reset test passed");
            passes++;
        end
        out_ready = 1'b1;
        rect_a = tbl[0].a;
        rect_b = tbl[0].b;
        in_valid = 1'b1;
        @(posedge clk);
        edges = 1;
        @(negedge clk);
        in_valid = 1'b0;
        while (out_valid !== 1'b1 && edges < 10) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (edges != 3) begin
            $display("First result took %0d cycles instead of 3", edges);
            errors++;
        end else if (is_collision !== tbl[0].hit) begin
            $display("Mismatch latency test: is_collision expected %h actual %h",
                     tbl[0].hit, is_collision);
            errors++;
        end else begin
            $display("Latency test passed");
            passes++;
        end

        run_stream();

        // Nothing may follow the last result
        repeat (6) begin
            @(negedge clk);
            out_ready = 1'b1;
            if (out_valid !== 1'b0) begin
                $display("An extra result appeared after the last input");
                errors++;
            end
        end

        $display("Tests passed: %0d, errors: %0d", passes, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
